/* source/cmd_pkg.sv */
// Shared command engine types; opcodes 6 to 15 are illegal and never reach the FIFO.
package cmd_pkg;

    // Widths that carry a meaning across the engine.
    typedef logic [15:0] data_t;
    typedef logic [3:0]  tag_t;
    typedef logic [7:0]  seq_t;
    typedef logic [3:0]  opcode_t;

    // Raw opcode encodings as presented by the host.
    localparam opcode_t OPC_LOAD = 4'd0;
    localparam opcode_t OPC_ADD  = 4'd1;
    localparam opcode_t OPC_SUB  = 4'd2;
    localparam opcode_t OPC_AND  = 4'd3;
    localparam opcode_t OPC_XOR  = 4'd4;
    localparam opcode_t OPC_READ = 4'd5;

    // Decoded operation, stored in the FIFO entry.
    typedef enum logic [2:0] {
        OP_LOAD = 3'd0,
        OP_ADD  = 3'd1,
        OP_SUB  = 3'd2,
        OP_AND  = 3'd3,
        OP_XOR  = 3'd4,
        OP_READ = 3'd5
    } exec_op_e;

    // Host command word, 24 bits.
    typedef struct packed {
        opcode_t opcode;
        tag_t    tag;
        data_t   operand;
    } cmd_word_t;

    // FIFO entry, 23 bits.
    typedef struct packed {
        exec_op_e op;
        tag_t     tag;
        data_t    operand;
    } dec_cmd_t;

    // Executor outcome, 21 bits.
    typedef struct packed {
        tag_t  tag;
        data_t value;
        logic  carry;
    } exec_out_t;

    // Tagged result at the top level, 30 bits.
    typedef struct packed {
        seq_t  seq;
        tag_t  tag;
        data_t value;
        logic  zero;
        logic  carry;
    } result_t;

endpackage

/* source/dp_ram.sv */
// Simple dual-port RAM; contents are undefined after power-up and a same-address read returns old data.
module dp_ram #(
    parameter int DATA_W    = 8,
    parameter int ADDR_W    = 8,
    parameter int RAM_DEPTH = (1 << ADDR_W)
) (
    input  logic              clk,
    input  logic              wr,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic              rd,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [RAM_DEPTH];

    // Write port.
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // The read data is registered and holds its value between read requests.
    always_ff @(posedge clk) begin
        if (rd) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* source/syn_fifo.sv */
// Synchronous FIFO with one-cycle read latency; callers must not write when full or read when empty.
module syn_fifo #(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr,
    input  logic              rd,
    input  logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    output logic              empty,
    output logic              full
);

    localparam int FIFO_DEPTH = 1 << ADDR_W;

    logic [ADDR_W-1:0] wr_pointer;
    logic [ADDR_W-1:0] rd_pointer;
    logic [ADDR_W:0]   status_cnt;

    assign full  = (status_cnt == (ADDR_W + 1)'(FIFO_DEPTH));
    assign empty = (status_cnt == '0);

    // Write pointer wraps at the last address.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_pointer <= '0;
        end else if (wr) begin
            if (wr_pointer == ADDR_W'(FIFO_DEPTH - 1)) begin
                wr_pointer <= '0;
            end else begin
                wr_pointer <= wr_pointer + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pointer <= '0;
        end else if (rd) begin
            if (rd_pointer == ADDR_W'(FIFO_DEPTH - 1)) begin
                rd_pointer <= '0;
            end else begin
                rd_pointer <= rd_pointer + 1'b1;
            end
        end
    end

    // A simultaneous read and write leaves the occupancy unchanged.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            status_cnt <= '0;
        end else if (rd && !wr && (status_cnt != '0)) begin
            status_cnt <= status_cnt - 1'b1;
        end else if (wr && !rd && !full) begin
            status_cnt <= status_cnt + 1'b1;
        end
    end

    dp_ram #(
        .DATA_W    (DATA_W),
        .ADDR_W    (ADDR_W),
        .RAM_DEPTH (FIFO_DEPTH)
    ) u_dp_ram (
        .clk     (clk),
        .wr      (wr),
        .wr_addr (wr_pointer),
        .wr_data (data_in),
        .rd      (rd),
        .rd_addr (rd_pointer),
        .rd_data (data_out)
    );

endmodule

/* source/cmd_decoder.sv */
// Command decoder; a legal command is written one cycle after its strobe, or lost if the FIFO is full.
module cmd_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_valid,
    input  cmd_pkg::cmd_word_t cmd,
    input  logic              full,
    output logic              wr,
    output cmd_pkg::dec_cmd_t wr_data,
    output logic              err_illegal,
    output logic              err_overflow
);

    cmd_pkg::exec_op_e dec_op;
    logic              legal;
    cmd_pkg::dec_cmd_t stage;
    logic              stage_valid;

    // Map the raw opcode onto the decoded operation.
    always_comb begin
        dec_op = cmd_pkg::OP_READ;
        legal  = 1'b1;
        case (cmd.opcode)
            cmd_pkg::OPC_LOAD: dec_op = cmd_pkg::OP_LOAD;
            cmd_pkg::OPC_ADD:  dec_op = cmd_pkg::OP_ADD;
            cmd_pkg::OPC_SUB:  dec_op = cmd_pkg::OP_SUB;
            cmd_pkg::OPC_AND:  dec_op = cmd_pkg::OP_AND;
            cmd_pkg::OPC_XOR:  dec_op = cmd_pkg::OP_XOR;
            cmd_pkg::OPC_READ: dec_op = cmd_pkg::OP_READ;
            default:           legal  = 1'b0;
        endcase
    end

    // One-entry stage holding the decoded command.
    always_ff @(posedge clk) begin
        if (cmd_valid && legal) begin
            stage.op      <= dec_op;
            stage.tag     <= cmd.tag;
            stage.operand <= cmd.operand;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage_valid <= 1'b0;
            err_illegal <= 1'b0;
        end else begin
            stage_valid <= cmd_valid && legal;
            err_illegal <= cmd_valid && !legal;
        end
    end

    // The full flag is sampled in the write cycle itself.
    assign wr           = stage_valid && !full;
    assign err_overflow = stage_valid && full;
    assign wr_data      = stage;

endmodule

/* source/cmd_executor.sv */
// Accumulator executor; runs one command every three cycles and holds the FIFO read data stable meanwhile.
module cmd_executor (
    input  logic               clk,
    input  logic               rst,
    input  logic               empty,
    output logic               rd,
    input  cmd_pkg::dec_cmd_t  rd_data,
    output logic               exec_valid,
    output cmd_pkg::exec_out_t exec_out
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EXEC
    } state_e;

    state_e            state;
    cmd_pkg::dec_cmd_t cur;
    cmd_pkg::data_t    acc;
    cmd_pkg::data_t    acc_next;
    logic              carry;
    logic [16:0]       wide;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (!empty) state <= FETCH;
                FETCH:   state <= EXEC;
                EXEC:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign rd = (state == IDLE) && !empty;

    // The registered RAM output is valid during FETCH.
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            cur <= rd_data;
        end
    end

    // Carry is the adder carry-out on ADD and the borrow on SUB.
    always_comb begin
        wide     = '0;
        acc_next = acc;
        carry    = 1'b0;
        case (cur.op)
            cmd_pkg::OP_LOAD: acc_next = cur.operand;
            cmd_pkg::OP_ADD: begin
                wide     = {1'b0, acc} + {1'b0, cur.operand};
                acc_next = wide[15:0];
                carry    = wide[16];
            end
            cmd_pkg::OP_SUB: begin
                wide     = {1'b0, acc} - {1'b0, cur.operand};
                acc_next = wide[15:0];
                carry    = wide[16];
            end
            cmd_pkg::OP_AND:  acc_next = acc & cur.operand;
            cmd_pkg::OP_XOR:  acc_next = acc ^ cur.operand;
            default:          acc_next = acc;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (state == EXEC) begin
            acc <= acc_next;
        end
    end

    assign exec_valid     = (state == EXEC);
    assign exec_out.tag   = cur.tag;
    assign exec_out.value = acc_next;
    assign exec_out.carry = carry;

endmodule

/* source/result_formatter.sv */
// Result stage; seq restarts at 0 on reset and wraps after 255 results.
module result_formatter (
    input  logic               clk,
    input  logic               rst,
    input  logic               exec_valid,
    input  cmd_pkg::exec_out_t exec_out,
    output logic               result_valid,
    output cmd_pkg::result_t   result
);

    cmd_pkg::seq_t seq;

    // Sequence counter, advanced once per result.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq <= '0;
        end else if (exec_valid) begin
            seq <= seq + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= exec_valid;
        end
    end

    // The payload is only meaningful while result_valid is high.
    always_ff @(posedge clk) begin
        if (exec_valid) begin
            result.seq   <= seq;
            result.tag   <= exec_out.tag;
            result.value <= exec_out.value;
            result.zero  <= (exec_out.value == '0);
            result.carry <= exec_out.carry;
        end
    end

endmodule

/* source/cmd_engine_top.sv */
// Command engine top; the host cannot be stalled, so commands arriving while the queue is full are lost.
module cmd_engine_top #(
    parameter int FIFO_ADDR_W = 3
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  cmd_pkg::cmd_word_t cmd,
    output logic               result_valid,
    output cmd_pkg::result_t   result,
    output logic               err_illegal,
    output logic               err_overflow
);

    localparam int ENTRY_W = $bits(cmd_pkg::dec_cmd_t);

    logic               fifo_wr;
    logic               fifo_rd;
    cmd_pkg::dec_cmd_t  fifo_wr_data;
    cmd_pkg::dec_cmd_t  fifo_rd_data;
    logic               fifo_empty;
    logic               fifo_full;
    logic               exec_valid;
    cmd_pkg::exec_out_t exec_out;

    cmd_decoder u_cmd_decoder (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .full         (fifo_full),
        .wr           (fifo_wr),
        .wr_data      (fifo_wr_data),
        .err_illegal  (err_illegal),
        .err_overflow (err_overflow)
    );

    // Command queue, one decoded entry per slot.
    syn_fifo #(
        .DATA_W (ENTRY_W),
        .ADDR_W (FIFO_ADDR_W)
    ) u_syn_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr       (fifo_wr),
        .rd       (fifo_rd),
        .data_in  (fifo_wr_data),
        .data_out (fifo_rd_data),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

    cmd_executor u_cmd_executor (
        .clk        (clk),
        .rst        (rst),
        .empty      (fifo_empty),
        .rd         (fifo_rd),
        .rd_data    (fifo_rd_data),
        .exec_valid (exec_valid),
        .exec_out   (exec_out)
    );

    result_formatter u_result_formatter (
        .clk          (clk),
        .rst          (rst),
        .exec_valid   (exec_valid),
        .exec_out     (exec_out),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* dv/cmd_engine_tb.sv */
// Random-stimulus testbench for the command engine; expects the default FIFO depth of 8 entries.
module cmd_engine_tb;

    localparam int N_SPARSE  = 200;
    localparam int N_CARRY   = 8;
    localparam int N_ILLEGAL = 120;
    localparam int N_BURST   = 40;
    localparam int N_RESET   = 21;
    localparam int DRAIN_LIMIT = 200;
    localparam int FIFO_ADDR_W = 3;
    localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;
    // Strobe, stage, dequeue, fetch and execute all come before the earliest result.
    localparam int MIN_LATENCY = 5;
    // Stimulus length of each test in cycles, taken at its widest spacing plus its drain.
    localparam int TEST_CYCLES = N_SPARSE * 6 + N_CARRY * 5 + N_ILLEGAL * 6 + N_BURST * 4
                               + N_RESET * 6 + 5 * 40;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES * 4 + 500;

    logic                 clk;
    logic                 rst;
    logic                 cmd_valid;
    cmd_pkg::cmd_word_t   cmd;
    logic                 result_valid;
    cmd_pkg::result_t     result;
    logic                 err_illegal;
    logic                 err_overflow;

    logic [31:0]          rng;
    cmd_pkg::data_t       model_acc;
    cmd_pkg::seq_t        model_seq;
    int                   model_fill;
    int                   model_busy;
    cmd_pkg::cmd_word_t   pend_cmd[$];
    int                   pend_cyc[$];
    int                   cycle;
    logic                 prev_legal;
    logic                 prev_illegal;
    logic                 expect_fresh;
    int                   checks;
    int                   err_count;
    int                   err_start;
    int                   n_results;
    int                   n_drops;
    int                   n_legal;
    int                   n_illegal;

    cmd_engine_top #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) u_cmd_engine_top (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .result_valid (result_valid),
        .result       (result),
        .err_illegal  (err_illegal),
        .err_overflow (err_overflow)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Opcodes 0 to 5 are the legal ones.
    function automatic logic is_legal(input cmd_pkg::opcode_t opc);
        return opc <= 4'd5;
    endfunction

    // Reference accumulator, advanced once per result in issue order.
    task automatic apply_model(input cmd_pkg::cmd_word_t c, output cmd_pkg::result_t exp);
        logic [16:0] sum;
        logic        cy;
        sum = '0;
        cy  = 1'b0;
        case (c.opcode)
            cmd_pkg::OPC_LOAD: model_acc = c.operand;
            cmd_pkg::OPC_ADD: begin
                sum       = {1'b0, model_acc} + {1'b0, c.operand};
                cy        = sum[16];
                model_acc = sum[15:0];
            end
            cmd_pkg::OPC_SUB: begin
                cy        = (model_acc < c.operand);
                model_acc = model_acc - c.operand;
            end
            cmd_pkg::OPC_AND: model_acc = model_acc & c.operand;
            cmd_pkg::OPC_XOR: model_acc = model_acc ^ c.operand;
            default: ;
        endcase
        exp.seq   = model_seq;
        exp.tag   = c.tag;
        exp.value = model_acc;
        exp.zero  = (model_acc == '0);
        exp.carry = cy;
        model_seq = model_seq + 1'b1;
    endtask

    task automatic check_result(input cmd_pkg::result_t got, input cmd_pkg::result_t exp);
        checks++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch result: got %h expected %h (seq %h/%h tag %h/%h value %h/%h)",
                     got, exp, got.seq, exp.seq, got.tag, exp.tag, got.value, exp.value);
        end
    endtask

    task automatic check_pulse(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            err_count++;
            if (exp) begin
                $display("missing %s pulse in cycle %0d", name, cycle);
            end else begin
                $display("unexpected %s pulse in cycle %0d", name, cycle);
            end
        end
    endtask

    // Monitor runs on the falling edge, where every DUT output is settled.
    always @(negedge clk) begin : monitor
        cmd_pkg::cmd_word_t c;
        cmd_pkg::result_t   exp;
        logic               ovf_exp;
        logic               pop_exp;
        int                 issued;
        cycle = cycle + 1;
        if (rst) begin
            pend_cmd.delete();
            pend_cyc.delete();
            model_acc    = '0;
            model_seq    = '0;
            model_fill   = 0;
            model_busy   = 0;
            prev_legal   = 1'b0;
            prev_illegal = 1'b0;
        end else begin
            check_pulse("err_illegal", err_illegal, prev_illegal);
            // A staged command is lost when the queue already holds FIFO_DEPTH entries.
            ovf_exp = prev_legal && (model_fill == FIFO_DEPTH);
            // The executor dequeues only while idle and then stays busy for two more cycles.
            pop_exp = (model_busy == 0) && (model_fill != 0);
            check_pulse("err_overflow", err_overflow, ovf_exp);
            if (err_illegal) n_illegal++;
            if (ovf_exp) begin
                // The dropped command is the one issued in the previous cycle.
                void'(pend_cmd.pop_back());
                void'(pend_cyc.pop_back());
                n_drops++;
            end
            if (prev_legal && !ovf_exp) begin
                model_fill++;
            end
            if (pop_exp) begin
                model_fill--;
                model_busy = 2;
            end else if (model_busy != 0) begin
                model_busy--;
            end
            if (result_valid) begin
                if (pend_cmd.size() == 0) begin
                    err_count++;
                    $display("result pulse in cycle %0d with no command pending", cycle);
                end else begin
                    c = pend_cmd.pop_front();
                    issued = pend_cyc.pop_front();
                    if (cycle - issued < MIN_LATENCY) begin
                        err_count++;
                        $display("result in cycle %0d for a command issued in cycle %0d is too early",
                                 cycle, issued);
                    end
                    apply_model(c, exp);
                    if (expect_fresh) begin
                        exp.seq      = '0;
                        exp.value    = '0;
                        exp.zero     = 1'b1;
                        exp.carry    = 1'b0;
                        expect_fresh = 1'b0;
                    end
                    check_result(result, exp);
                    n_results++;
                end
            end
            prev_legal   = cmd_valid && is_legal(cmd.opcode);
            prev_illegal = cmd_valid && !is_legal(cmd.opcode);
            if (prev_legal) begin
                pend_cmd.push_back(cmd);
                pend_cyc.push_back(cycle);
                n_legal++;
            end
        end
    end

    task automatic issue(input cmd_pkg::opcode_t opc, input cmd_pkg::tag_t tag,
                         input cmd_pkg::data_t operand);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= {opc, tag, operand};
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
        end
    endtask

    task automatic send_random(input int min_gap, input int spread, input logic with_illegal);
        cmd_pkg::opcode_t opc;
        int               gap;
        rng = xorshift32(rng);
        opc = cmd_pkg::opcode_t'(rng[15:8] % 6);
        if (with_illegal && rng[3:0] < 4'd5) begin
            opc = cmd_pkg::opcode_t'(6 + rng[23:20] % 10);
        end
        issue(opc, rng[7:4], rng[31:16]);
        rng = xorshift32(rng);
        gap = min_gap + ((spread > 0) ? int'(rng[7:0]) % spread : 0);
        idle(gap);
    endtask

    task automatic start_test();
        err_start      = err_count;
        n_results      = 0;
        n_drops        = 0;
        n_legal        = 0;
        n_illegal      = 0;
    endtask

    task automatic finish_test(input int num, input string name);
        int waited;
        idle(3);
        waited = 0;
        while (pend_cmd.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (pend_cmd.size() != 0) begin
            err_count++;
            $display("%0d commands got no result within %0d cycles", pend_cmd.size(), waited);
        end
        $display("test %0d %s: %0d results, %0d drops, %0d illegal, %0d errors",
                 num, name, n_results, n_drops, n_illegal, err_count - err_start);
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        clk = 1'b0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        rng = 32'hd977;
        cycle = 0;
        checks = 0;
        err_count = 0;
        expect_fresh = 1'b0;
        start_test();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        idle(2);

        start_test();
        repeat (N_SPARSE) send_random(3, 3, 1'b0);
        finish_test(1, "sparse legal commands");

        // Operands chosen so that ADD and SUB wrap past 16 bits.
        start_test();
        issue(cmd_pkg::OPC_LOAD, 4'h1, 16'hffff);
        idle(4);
        issue(cmd_pkg::OPC_ADD, 4'h2, 16'h0001);
        idle(4);
        issue(cmd_pkg::OPC_ADD, 4'h3, 16'h8000);
        idle(4);
        issue(cmd_pkg::OPC_ADD, 4'h4, 16'h8000);
        idle(4);
        issue(cmd_pkg::OPC_SUB, 4'h5, 16'h0001);
        idle(4);
        issue(cmd_pkg::OPC_SUB, 4'h6, 16'hffff);
        idle(4);
        issue(cmd_pkg::OPC_LOAD, 4'h7, 16'h1234);
        idle(4);
        issue(cmd_pkg::OPC_SUB, 4'h8, 16'h1235);
        finish_test(2, "carry and borrow");

        start_test();
        repeat (N_ILLEGAL) send_random(3, 3, 1'b1);
        finish_test(3, "illegal opcodes");
        if (n_illegal == 0) begin
            err_count++;
            $display("no illegal opcode was flagged");
        end

        start_test();
        repeat (N_BURST) send_random(0, 0, 1'b0);
        finish_test(4, "overflow burst");
        if (n_drops == 0) begin
            err_count++;
            $display("the burst never overflowed the queue");
        end
        if (n_results + n_drops != n_legal) begin
            err_count++;
            $display("%0d results and %0d drops do not account for %0d commands",
                     n_results, n_drops, n_legal);
        end

        start_test();
        repeat (12) send_random(1, 2, 1'b0);
        @(posedge clk);
        rst       <= 1'b1;
        cmd_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        idle(2);
        expect_fresh = 1'b1;
        issue(cmd_pkg::OPC_READ, 4'ha, 16'h5a5a);
        idle(4);
        repeat (N_RESET - 13) send_random(3, 3, 1'b0);
        finish_test(5, "reset recovery");
        if (expect_fresh) begin
            err_count++;
            $display("no result came back for the read after reset");
        end

        $display("%0d checks, %0d errors", checks, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
source/cmd_pkg.sv
source/dp_ram.sv
source/syn_fifo.sv
source/cmd_decoder.sv
source/cmd_executor.sv
source/result_formatter.sv
source/cmd_engine_top.sv
dv/cmd_engine_tb.sv

/* Bender.yml */
package:
  name: cmd_engine

sources:
  - files:
      - source/cmd_pkg.sv
      - source/dp_ram.sv
      - source/syn_fifo.sv
      - source/cmd_decoder.sv
      - source/cmd_executor.sv
      - source/result_formatter.sv
      - source/cmd_engine_top.sv
  - target: simulation
    files:
      - dv/cmd_engine_tb.sv
